// File: verilog/burst_pkg.sv
`default_nettype none

package burst_pkg;

  localparam int n_ports = 2;
  localparam int addr_w = 8;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;
  localparam int len_w = 4; // Beats minus one.
  localparam int mem_depth = 2 ** addr_w;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;
  typedef logic [strb_w-1:0] strb_t;
  typedef logic [len_w-1:0]  len_t;

  // Wide enough to index any of the request ports.
  typedef logic [0:0] port_sel_t;

  typedef enum logic {
    mem_idle,
    mem_busy
  } mem_state_t;

endpackage

`default_nettype wire

// File: verilog/burst_merge.sv
`timescale 1ns/1ps
`default_nettype none

module burst_merge (
  input  wire                                              clk,
  input  wire                                              rst,
  input  wire  [burst_pkg::n_ports-1:0]                    s_valid,
  output logic [burst_pkg::n_ports-1:0]                    s_ready,
  output logic [burst_pkg::n_ports-1:0]                    s_last,
  input  wire  burst_pkg::addr_t [burst_pkg::n_ports-1:0]  s_addr,
  input  wire  burst_pkg::data_t [burst_pkg::n_ports-1:0]  s_wdata,
  input  wire  burst_pkg::strb_t [burst_pkg::n_ports-1:0]  s_wstrb,
  input  wire  burst_pkg::len_t [burst_pkg::n_ports-1:0]   s_len,
  output burst_pkg::data_t                                 s_rdata,
  output logic                                             m_wvalid,
  input  wire                                              m_wready,
  output burst_pkg::addr_t                                 m_waddr,
  output burst_pkg::data_t                                 m_wdata,
  output burst_pkg::strb_t                                 m_wstrb,
  output burst_pkg::len_t                                  m_wlen,
  input  wire                                              m_wlast,
  output logic                                             m_rvalid,
  input  wire                                              m_rready,
  output burst_pkg::addr_t                                 m_raddr,
  output burst_pkg::len_t                                  m_rlen,
  input  wire                                              m_rlast,
  input  wire  burst_pkg::data_t                           m_rdata
);
  import burst_pkg::*;

  logic      w_req_valid;
  port_sel_t w_req;
  logic      r_req_valid;
  port_sel_t r_req;

  logic      w_running;
  port_sel_t w_sel;
  logic      r_running;
  port_sel_t r_sel;

  logic      w_done;
  logic      r_done;

  // A nonzero strobe marks a write. Scanning upward lets the highest port win.
  always_comb begin
    w_req_valid = 1'b0;
    w_req = '0;
    r_req_valid = 1'b0;
    r_req = '0;
    for (int i = 0; i < n_ports; i++) begin
      if (s_valid[i]) begin
        if (|s_wstrb[i]) begin
          w_req_valid = 1'b1;
          w_req = port_sel_t'(i);
        end else begin
          r_req_valid = 1'b1;
          r_req = port_sel_t'(i);
        end
      end
    end
  end

  assign w_done = w_running && m_wvalid && m_wready && m_wlast;
  assign r_done = r_running && m_rvalid && m_rready && m_rlast;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      w_running <= 1'b0;
      w_sel <= '0;
      r_running <= 1'b0;
      r_sel <= '0;
    end else begin
      if (!w_running && w_req_valid) begin
        w_running <= 1'b1;
        w_sel <= w_req;
      end else if (w_done) begin
        w_running <= 1'b0; // Channel is free again from the next cycle.
      end
      if (!r_running && r_req_valid) begin
        r_running <= 1'b1;
        r_sel <= r_req;
      end else if (r_done) begin
        r_running <= 1'b0;
      end
    end
  end

  // Memory side sees only the granted port, and nothing while idle.
  always_comb begin
    m_wvalid = 1'b0;
    m_waddr = '0;
    m_wdata = '0;
    m_wstrb = '0;
    m_wlen = '0;
    m_rvalid = 1'b0;
    m_raddr = '0;
    m_rlen = '0;
    if (w_running) begin
      m_wvalid = s_valid[w_sel];
      m_waddr = s_addr[w_sel];
      m_wdata = s_wdata[w_sel];
      m_wstrb = s_wstrb[w_sel];
      m_wlen = s_len[w_sel];
    end
    if (r_running) begin
      m_rvalid = s_valid[r_sel];
      m_raddr = s_addr[r_sel];
      m_rlen = s_len[r_sel];
    end
  end

  // Each channel answers only its own port. The two results are merged per bit.
  always_comb begin
    for (int k = 0; k < n_ports; k++) begin
      s_ready[k] = (w_running && w_sel == port_sel_t'(k) && m_wready) ||
                   (r_running && r_sel == port_sel_t'(k) && m_rready);
      s_last[k]  = (w_running && w_sel == port_sel_t'(k) && m_wlast) ||
                   (r_running && r_sel == port_sel_t'(k) && m_rlast);
    end
  end

  assign s_rdata = m_rdata; // Shared by both ports.

endmodule

`default_nettype wire

// File: verilog/burst_mem.sv
`timescale 1ns/1ps
`default_nettype none

module burst_mem (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    stall,
  input  wire                    wvalid,
  output logic                   wready,
  input  wire  burst_pkg::addr_t waddr,
  input  wire  burst_pkg::data_t wdata,
  input  wire  burst_pkg::strb_t wstrb,
  input  wire  burst_pkg::len_t  wlen,
  output logic                   wlast,
  input  wire                    rvalid,
  output logic                   rready,
  input  wire  burst_pkg::addr_t raddr,
  input  wire  burst_pkg::len_t  rlen,
  output logic                   rlast,
  output burst_pkg::data_t       rdata
);
  import burst_pkg::*;

  data_t mem [mem_depth];

  mem_state_t w_state;
  addr_t      w_base;
  len_t       w_len;
  len_t       w_cnt;
  addr_t      w_addr_cur;
  logic       w_xfer;

  mem_state_t r_state;
  addr_t      r_base;
  len_t       r_len;
  len_t       r_cnt;
  addr_t      r_addr_cur;
  logic       r_xfer;

  // On the first beat the live request fields are used directly.
  function automatic addr_t beat_addr(mem_state_t st, addr_t live, addr_t base, len_t cnt);
    return (st == mem_idle) ? live : base + addr_t'(cnt);
  endfunction

  function automatic logic beat_last(mem_state_t st, logic valid, len_t live, len_t len_q,
                                     len_t cnt);
    logic active;
    active = (st == mem_busy) || valid;
    return active && (cnt == ((st == mem_idle) ? live : len_q));
  endfunction

  assign wready = !stall;
  assign rready = !stall;

  assign w_xfer = wvalid && wready;
  assign r_xfer = rvalid && rready;

  assign w_addr_cur = beat_addr(w_state, waddr, w_base, w_cnt);
  assign r_addr_cur = beat_addr(r_state, raddr, r_base, r_cnt);

  assign wlast = beat_last(w_state, wvalid, wlen, w_len, w_cnt);
  assign rlast = beat_last(r_state, rvalid, rlen, r_len, r_cnt);

  // Combinational read, so a same-cycle write to this word is not yet visible.
  assign rdata = mem[r_addr_cur];

  always_ff @(posedge clk) begin
    if (w_xfer) begin
      for (int b = 0; b < strb_w; b++) begin
        if (wstrb[b]) mem[w_addr_cur][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      w_state <= mem_idle;
      w_base <= '0;
      w_len <= '0;
      w_cnt <= '0;
      r_state <= mem_idle;
      r_base <= '0;
      r_len <= '0;
      r_cnt <= '0;
    end else begin
      if (w_xfer) begin
        if (w_state == mem_idle) begin
          w_base <= waddr;
          w_len <= wlen;
        end
        w_state <= wlast ? mem_idle : mem_busy;
        w_cnt <= wlast ? '0 : w_cnt + 1'b1;
      end
      if (r_xfer) begin
        if (r_state == mem_idle) begin
          r_base <= raddr;
          r_len <= rlen;
        end
        r_state <= rlast ? mem_idle : mem_busy;
        r_cnt <= rlast ? '0 : r_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/burst_top.sv
`timescale 1ns/1ps
`default_nettype none

module burst_top (
  input  wire                                              clk,
  input  wire                                              rst,
  input  wire                                              mem_stall,
  input  wire  [burst_pkg::n_ports-1:0]                    p_valid,
  output logic [burst_pkg::n_ports-1:0]                    p_ready,
  output logic [burst_pkg::n_ports-1:0]                    p_last,
  input  wire  burst_pkg::addr_t [burst_pkg::n_ports-1:0]  p_addr,
  input  wire  burst_pkg::data_t [burst_pkg::n_ports-1:0]  p_wdata,
  input  wire  burst_pkg::strb_t [burst_pkg::n_ports-1:0]  p_wstrb,
  input  wire  burst_pkg::len_t [burst_pkg::n_ports-1:0]   p_len,
  output burst_pkg::data_t                                 p_rdata
);
  import burst_pkg::*;

  logic  wvalid;
  logic  wready;
  addr_t waddr;
  data_t wdata;
  strb_t wstrb;
  len_t  wlen;
  logic  wlast;

  logic  rvalid;
  logic  rready;
  addr_t raddr;
  len_t  rlen;
  logic  rlast;
  data_t rdata;

  burst_merge merge (
    .clk(clk), .rst(rst),
    .s_valid(p_valid), .s_ready(p_ready), .s_last(p_last),
    .s_addr(p_addr), .s_wdata(p_wdata), .s_wstrb(p_wstrb), .s_len(p_len),
    .s_rdata(p_rdata),
    .m_wvalid(wvalid), .m_wready(wready), .m_waddr(waddr), .m_wdata(wdata),
    .m_wstrb(wstrb), .m_wlen(wlen), .m_wlast(wlast),
    .m_rvalid(rvalid), .m_rready(rready), .m_raddr(raddr), .m_rlen(rlen),
    .m_rlast(rlast), .m_rdata(rdata)
  );

  burst_mem mem (
    .clk(clk), .rst(rst), .stall(mem_stall),
    .wvalid(wvalid), .wready(wready), .waddr(waddr), .wdata(wdata),
    .wstrb(wstrb), .wlen(wlen), .wlast(wlast),
    .rvalid(rvalid), .rready(rready), .raddr(raddr), .rlen(rlen),
    .rlast(rlast), .rdata(rdata)
  );

endmodule

`default_nettype wire

// File: tb/burst_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module burst_asserts (
  input wire                          clk,
  input wire                          rst,
  input wire                          mem_stall,
  input wire [burst_pkg::n_ports-1:0] p_valid,
  input wire [burst_pkg::n_ports-1:0] p_ready,
  input wire [burst_pkg::n_ports-1:0] p_last,
  input wire                          w_running,
  input wire burst_pkg::port_sel_t    w_sel,
  input wire                          r_running,
  input wire burst_pkg::port_sel_t    r_sel
);
  import burst_pkg::*;

  int fails = 0; // Watched by the testbench.

  // Nothing comes back to the ports while no port requests.
  idle_quiet: assert property (@(posedge clk) disable iff (rst)
    (p_valid == '0) |-> (p_ready == '0 && p_last == '0))
    else begin
      $error("ready or last high while no port is requesting");
      fails++;
    end

  stall_blocks: assert property (@(posedge clk) disable iff (rst)
    mem_stall |-> p_ready == '0)
    else begin
      $error("a port saw ready during a memory stall");
      fails++;
    end

  // A port is classified by its strobe, so it can never own both channels.
  one_channel: assert property (@(posedge clk) disable iff (rst)
    !(w_running && r_running && w_sel == r_sel))
    else begin
      $error("one port granted the write and the read channel together");
      fails++;
    end

  // Ports hold valid through a whole burst, so ready without valid is a stale grant.
  for (genvar k = 0; k < n_ports; k++) begin : g_port
    ready_owner: assert property (@(posedge clk) disable iff (rst)
      p_ready[k] |-> p_valid[k])
      else begin
        $error("ready on a port with no valid");
        fails++;
      end
  end

  w_release: assert property (@(posedge clk) disable iff (rst)
    (w_running && p_valid[w_sel] && p_ready[w_sel] && p_last[w_sel]) |=> !w_running)
    else begin
      $error("write grant held after the last beat");
      fails++;
    end

  r_release: assert property (@(posedge clk) disable iff (rst)
    (r_running && p_valid[r_sel] && p_ready[r_sel] && p_last[r_sel]) |=> !r_running)
    else begin
      $error("read grant held after the last beat");
      fails++;
    end

endmodule

bind burst_top burst_asserts asserts_i (
  .clk(clk), .rst(rst), .mem_stall(mem_stall),
  .p_valid(p_valid), .p_ready(p_ready), .p_last(p_last),
  .w_running(merge.w_running), .w_sel(merge.w_sel),
  .r_running(merge.r_running), .r_sel(merge.r_sel)
);

`default_nettype wire

// File: tb/burst_tb.sv
`timescale 1ns/1ps
`default_nettype none

module burst_tb;
  import burst_pkg::*;

  logic                clk;
  logic                rst;
  logic                mem_stall;
  logic [n_ports-1:0]  p_valid;
  logic [n_ports-1:0]  p_ready;
  logic [n_ports-1:0]  p_last;
  addr_t [n_ports-1:0] p_addr;
  data_t [n_ports-1:0] p_wdata;
  strb_t [n_ports-1:0] p_wstrb;
  len_t [n_ports-1:0]  p_len;
  data_t               p_rdata;

  data_t model [mem_depth]; // Reference copy of the memory.
  len_t  beat [n_ports];
  time   done_at [n_ports];
  int    seed;
  int    cycles;
  logic  stall_on;

  burst_top DUT (
    .clk(clk), .rst(rst), .mem_stall(mem_stall),
    .p_valid(p_valid), .p_ready(p_ready), .p_last(p_last),
    .p_addr(p_addr), .p_wdata(p_wdata), .p_wstrb(p_wstrb), .p_len(p_len),
    .p_rdata(p_rdata)
  );

  always #20 clk = ~clk;

  task automatic stop_failed();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    stop_failed();
  endtask

  task automatic abort_run(input string msg);
    $display("Run aborted at %0t: %s", $time, msg);
    stop_failed();
  endtask

  function automatic data_t fill_word(addr_t a);
    return {a, ~a, a ^ 8'h5a, a + 8'h33};
  endfunction

  // One whole burst on port k. A zero strobe makes it a read.
  task automatic drive_burst(input int k, input addr_t a, input len_t l, input strb_t s,
                             input bit fill);
    int beats;
    bit done;
    bit moved;
    beats = 0;
    done = 1'b0;
    @(negedge clk);
    p_valid[k] = 1'b1;
    p_addr[k] = a;
    p_len[k] = l;
    p_wstrb[k] = s;
    p_wdata[k] = fill ? fill_word(a) : data_t'($random(seed));
    while (!done) begin
      @(posedge clk);
      moved = p_ready[k];
      if (moved) begin
        beats++;
        done = p_last[k];
      end
      @(negedge clk);
      if (moved && !done) begin
        p_wdata[k] = fill ? fill_word(a + addr_t'(beats)) : data_t'($random(seed));
      end
    end
    p_valid[k] = 1'b0;
    p_wstrb[k] = '0;
    done_at[k] = $time;
    assert (beats == int'(l) + 1)
      else mismatch($sformatf("port %0d burst took %0d beats for len %0d", k, beats, l));
  endtask

  task automatic write_read(input int k, input addr_t a, input len_t l, input strb_t s);
    drive_burst(k, a, l, s, 1'b0);
    drive_burst(k, a, l, '0, 1'b0);
  endtask

  // Write on one port and read on the other, in disjoint halves of the memory.
  task automatic cross_traffic(input int wr_port);
    addr_t wa;
    addr_t ra;
    len_t  wl;
    len_t  rl;
    wa = addr_t'($random(seed)) & 8'h6f;
    ra = (addr_t'($random(seed)) & 8'h6f) | 8'h80;
    wl = len_t'($random(seed));
    rl = len_t'($random(seed));
    fork
      drive_burst(wr_port, wa, wl, '1, 1'b0);
      drive_burst(1 - wr_port, ra, rl, '0, 1'b0);
    join
  endtask

  // Reads are checked before this edge's writes reach the model.
  always @(posedge clk) begin
    addr_t a;
    if (!rst) begin
      for (int k = 0; k < n_ports; k++) begin
        if (p_valid[k] && p_ready[k] && p_wstrb[k] == '0) begin
          a = p_addr[k] + addr_t'(beat[k]);
          assert (p_rdata == model[a])
            else mismatch($sformatf("port %0d read %h at %h, expected %h",
                                    k, p_rdata, a, model[a]));
        end
      end
      for (int k = 0; k < n_ports; k++) begin
        if (p_valid[k] && p_ready[k]) begin
          assert (p_last[k] == (beat[k] == p_len[k]))
            else mismatch($sformatf("port %0d last=%b on beat %0d of len %0d",
                                    k, p_last[k], beat[k], p_len[k]));
          if (p_wstrb[k] != '0) begin
            a = p_addr[k] + addr_t'(beat[k]);
            for (int b = 0; b < strb_w; b++) begin
              if (p_wstrb[k][b]) model[a][8*b +: 8] = p_wdata[k][8*b +: 8];
            end
          end
          beat[k] = p_last[k] ? '0 : beat[k] + len_t'(1);
        end
      end
    end
  end

  always @(negedge clk) begin
    mem_stall = stall_on && (($random(seed) & 3) < 2);
    cycles++;
    if (cycles >= 6000) begin
      abort_run("timeout, the bursts did not finish within 6000 cycles");
    end else if (DUT.asserts_i.fails != 0) begin
      abort_run("a protocol assertion on the DUT failed");
    end
  end

  initial begin
    addr_t a;
    len_t  l;
    strb_t s;
    int    k;
    seed = 2560;
    clk = 1'b0;
    rst = 1'b1;
    mem_stall = 1'b0;
    stall_on = 1'b0;
    cycles = 0;
    p_valid = '0;
    p_addr = '0;
    p_wdata = '0;
    p_wstrb = '0;
    p_len = '0;
    for (int i = 0; i < n_ports; i++) beat[i] = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < mem_depth / 16; i++) begin
      drive_burst(0, addr_t'(16 * i), '1, '1, 1'b1);
    end
    for (int i = 0; i < 16; i++) begin
      k = $random(seed) & 1;
      a = addr_t'($random(seed));
      write_read(k, a, len_t'(i), '1);
    end
    for (int i = 0; i < 8; i++) begin
      k = $random(seed) & 1;
      a = addr_t'($random(seed));
      l = len_t'($random(seed));
      s = strb_t'($random(seed));
      if (s == '0) s = strb_t'(1);
      write_read(k, a, l, s);
    end
    for (int i = 0; i < 6; i++) cross_traffic(i % 2);
    // Same channel on both ports at once. The higher port goes first.
    for (int i = 0; i < 2; i++) begin
      s = (i == 0) ? '1 : '0;
      fork
        drive_burst(0, 8'h20, 4'd5, s, 1'b0);
        drive_burst(1, 8'h60, 4'd5, s, 1'b0);
      join
      assert (done_at[1] < done_at[0])
        else mismatch("port 0 finished before port 1 on a shared channel");
    end
    stall_on = 1'b1;
    for (int i = 0; i < 8; i++) cross_traffic(i % 2);
    stall_on = 1'b0;
    for (int i = 0; i < mem_depth / 16; i++) begin
      drive_burst(1, addr_t'(16 * i), '1, '0, 1'b0);
    end
    repeat (2) @(negedge clk);
    if (DUT.asserts_i.fails == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abort_run("protocol assertions failed during the run");
    end
  end

endmodule

`default_nettype wire

// File: sim.f
verilog/burst_pkg.sv
verilog/burst_merge.sv
verilog/burst_mem.sv
verilog/burst_top.sv
tb/burst_asserts.sv
tb/burst_tb.sv

// File: Makefile
SRCS := sim.f $(wildcard verilog/*.sv tb/*.sv)

all: run

obj_dir/Vburst_tb: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	  --top-module burst_tb -f sim.f -o Vburst_tb

run: obj_dir/Vburst_tb
	./obj_dir/Vburst_tb +verilator+error+limit+100 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
